//--- sources.f
+incdir+include
hw/bus_pkg.sv
hw/periph_pkg.sv
hw/bus_if.sv
hw/data_bus.sv
hw/ram_controller.sv
hw/timer_controller.sv
hw/gpio_controller.sv
hw/thinpad_soc.sv
tests/tb_thinpad_soc.sv

//--- Bender.yml
package:
  name: thinpad_soc

export_include_dirs:
  - include

sources:
  - hw/bus_pkg.sv
  - hw/periph_pkg.sv
  - hw/bus_if.sv
  - hw/data_bus.sv
  - hw/ram_controller.sv
  - hw/timer_controller.sv
  - hw/gpio_controller.sv
  - hw/thinpad_soc.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_thinpad_soc.sv

//--- tests/tb_thinpad_soc.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module tb_thinpad_soc;
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int CHECK_ALL    = 0;
    localparam int CHECK_NONE   = 1;  // polling reads
    localparam int CHECK_RISING = 2;  // timer count must grow

    logic                       clk;
    logic                       reset;
    logic                       req_strobe;
    logic                       req_write;
    addr_t                      req_addr;
    word_t                      req_wdata;
    be_t                        req_be;
    logic                       resp_ack;
    word_t                      resp_rdata;
    logic                       resp_error;
    logic [`SOC_GPIO_WIDTH-1:0] gpio_in;
    logic [`SOC_GPIO_WIDTH-1:0] gpio_out;
    logic                       timer_irq;

    word_t                      shadow_ram [`SOC_RAM_WORDS];
    logic [`SOC_GPIO_WIDTH-1:0] shadow_gpio;
    logic [31:0]                lcg_state;
    int                         cycle = 0;
    int                         value_errors = 0;
    int                         other_errors = 0;
    word_t                      last_rdata;
    word_t                      last_count;
    logic                       count_seen;

    // outstanding requests in issue order
    word_t exp_rdata [$];
    logic  exp_error [$];
    int    exp_kind [$];
    int    exp_cycle [$];
    string exp_name [$];

    thinpad_soc UUT (
        .clk, .reset, .req_strobe, .req_write, .req_addr, .req_wdata, .req_be,
        .resp_ack, .resp_rdata, .resp_error, .gpio_in, .gpio_out, .timer_irq
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    // expected {error, rdata} of one access against the shadow state
    function automatic logic [`SOC_DATA_WIDTH:0] predict_access(input logic write,
            input addr_t addr, input word_t wdata, input be_t be);
        dev_sel_t dev;
        word_t    rdata;
        int       index;
        rdata = '0;
        index = int'(addr[27:0]) / 4;
        case (addr[31:28])
            `SOC_RAM_BASE >> 28:   dev = (addr[27:0] < 4 * `SOC_RAM_WORDS) ? DEV_RAM : DEV_NONE;
            `SOC_TIMER_BASE >> 28: dev = DEV_TIMER;
            `SOC_GPIO_BASE >> 28:  dev = DEV_GPIO;
            default:               dev = DEV_NONE;
        endcase
        if (dev == DEV_RAM && write) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) shadow_ram[index][8*i +: 8] = wdata[8*i +: 8];
            end
        end else if (dev == DEV_RAM) begin
            rdata = shadow_ram[index];
        end else if (dev == DEV_GPIO && addr[3:0] == GPIO_OUT) begin
            if (write) shadow_gpio = wdata[`SOC_GPIO_WIDTH-1:0];
            else rdata = word_t'(shadow_gpio);
        end else if (dev == DEV_GPIO && addr[3:0] == GPIO_IN && !write) begin
            rdata = word_t'(gpio_in);
        end
        return {dev == DEV_NONE, rdata};
    endfunction

    // one strobe on the current falling edge
    task automatic issue(input string name, input logic write, input addr_t addr,
                         input word_t wdata, input be_t be, input int kind);
        logic [`SOC_DATA_WIDTH:0] expected;
        expected   = predict_access(write, addr, wdata, be);
        req_strobe = 1'b1;
        req_write  = write;
        req_addr   = addr;
        req_wdata  = wdata;
        req_be     = be;
        exp_error.push_back(expected[`SOC_DATA_WIDTH]);
        exp_rdata.push_back(expected[`SOC_DATA_WIDTH-1:0]);
        exp_kind.push_back(kind);
        exp_cycle.push_back(cycle + 2);
        exp_name.push_back(name);
        @(negedge clk);
        req_strobe = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_kind.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_kind.size() != 0) begin
            $display("timeout waiting for %0d outstanding responses", exp_kind.size());
            other_errors++;
        end
        @(negedge clk);
    endtask

    always @(negedge clk) begin
        string name;
        int    kind;
        int    due;
        word_t rdata;
        logic  error;
        if (!reset && resp_ack && exp_kind.size() == 0) begin
            $display("ack seen with no request outstanding");
            other_errors++;
        end else if (!reset && exp_kind.size() != 0 && (resp_ack || exp_cycle[0] < cycle)) begin
            name  = exp_name.pop_front();
            kind  = exp_kind.pop_front();
            due   = exp_cycle.pop_front();
            rdata = exp_rdata.pop_front();
            error = exp_error.pop_front();
            if (!resp_ack) begin
                $display("%s: no ack arrived two cycles after the strobe", name);
                other_errors++;
            end else begin
                last_rdata = resp_rdata;
                if (due != cycle) begin
                    $display("ERR %s ack cycle expected %0d actual %0d", name, due, cycle);
                    value_errors++;
                end
                if (resp_error !== error) begin
                    $display("ERR %s error expected %b actual %b", name, error, resp_error);
                    value_errors++;
                end
                if (kind == CHECK_ALL && resp_rdata !== rdata) begin
                    $display("ERR %s rdata expected %h actual %h", name, rdata, resp_rdata);
                    value_errors++;
                end
                if (kind == CHECK_RISING && count_seen && resp_rdata <= last_count) begin
                    $display("ERR %s count expected above %h actual %h", name, last_count,
                             resp_rdata);
                    value_errors++;
                end
                if (kind == CHECK_RISING) begin
                    last_count = resp_rdata;
                    count_seen = 1'b1;
                end
            end
        end
    end

    initial begin
        addr_t ram_addrs [$];
        addr_t addr;
        word_t value;
        int    tries;
        lcg_state   = 32'd22650;
        shadow_gpio = '0;
        count_seen  = 1'b0;
        reset       = 1'b1;
        req_strobe  = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_be      = '0;
        gpio_in     = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        if (resp_ack !== 1'b0 || resp_error !== 1'b0 || timer_irq !== 1'b0) begin
            $display("ERR reset_state flags expected 000 actual %b%b%b",
                     resp_ack, resp_error, timer_irq);
            value_errors++;
        end
        if (gpio_out !== '0) begin
            $display("ERR reset_state gpio_out expected 0000 actual %h", gpio_out);
            value_errors++;
        end

        // back-to-back word writes then reads
        for (int i = 0; i < 8; i++) begin
            addr = addr_t'(lcg_next() % `SOC_RAM_WORDS) * 4;
            ram_addrs.push_back(addr);
            issue("ram_word_write", 1'b1, addr, lcg_next(), 4'hF, CHECK_ALL);
        end
        foreach (ram_addrs[i]) issue("ram_word_read", 1'b0, ram_addrs[i], '0, 4'hF, CHECK_ALL);
        drain();

        foreach (ram_addrs[i]) begin
            issue("ram_byte_write", 1'b1, ram_addrs[i], lcg_next(), be_t'(lcg_next()), CHECK_ALL);
            issue("ram_byte_read", 1'b0, ram_addrs[i], '0, 4'hF, CHECK_ALL);
        end
        drain();

        for (int i = 0; i < 4; i++) begin
            value = lcg_next();
            addr  = {4'(3 + value[31:28] % 13), value[27:0]};
            issue("unmapped", i[0], addr, lcg_next(), 4'hF, CHECK_ALL);
            addr = 32'h0000_1000 + ((lcg_next() % 32'h0FFF_F000) & ~32'h3);
            issue("ram_past_end", !i[0], addr, lcg_next(), 4'hF, CHECK_ALL);
        end
        drain();

        issue("gpio_out_write", 1'b1, `SOC_GPIO_BASE + GPIO_OUT, lcg_next(), 4'hF, CHECK_ALL);
        drain();
        if (gpio_out !== shadow_gpio) begin
            $display("ERR gpio_out_pins expected %h actual %h", shadow_gpio, gpio_out);
            value_errors++;
        end
        issue("gpio_out_read", 1'b0, `SOC_GPIO_BASE + GPIO_OUT, '0, 4'hF, CHECK_ALL);
        gpio_in = 16'(lcg_next());
        tries   = 0;
        do begin
            issue("gpio_in_poll", 1'b0, `SOC_GPIO_BASE + GPIO_IN, '0, 4'hF, CHECK_NONE);
            drain();
            tries++;
        end while (last_rdata !== word_t'(gpio_in) && tries < 8);
        if (last_rdata !== word_t'(gpio_in)) begin
            $display("timeout waiting for gpio_in to reach the GPIO_IN register");
            other_errors++;
        end
        issue("gpio_in_write", 1'b1, `SOC_GPIO_BASE + GPIO_IN, lcg_next(), 4'hF, CHECK_ALL);
        issue("gpio_in_read", 1'b0, `SOC_GPIO_BASE + GPIO_IN, '0, 4'hF, CHECK_ALL);
        issue("gpio_out_keep", 1'b0, `SOC_GPIO_BASE + GPIO_OUT, '0, 4'hF, CHECK_ALL);
        drain();

        issue("timer_compare", 1'b1, `SOC_TIMER_BASE + TIMER_COMPARE, 32'd40, 4'hF, CHECK_ALL);
        issue("timer_enable", 1'b1, `SOC_TIMER_BASE + TIMER_CTRL, 32'd1, 4'hF, CHECK_ALL);
        drain();
        tries = 0;
        while (!timer_irq && tries < 200) begin
            @(negedge clk);
            tries++;
        end
        if (!timer_irq) begin
            $display("timeout waiting for timer_irq to rise");
            other_errors++;
        end
        for (int i = 0; i < 3; i++) begin
            issue("timer_count", 1'b0, `SOC_TIMER_BASE + TIMER_COUNT, '0, 4'hF, CHECK_RISING);
        end
        issue("timer_disable", 1'b1, `SOC_TIMER_BASE + TIMER_CTRL, 32'd0, 4'hF, CHECK_ALL);
        drain();
        if (timer_irq !== 1'b0) begin
            $display("ERR timer_irq_clear expected 0 actual %b", timer_irq);
            value_errors++;
        end

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/thinpad_soc.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module thinpad_soc (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req_strobe,
    input  logic                       req_write,
    input  logic [`SOC_ADDR_WIDTH-1:0] req_addr,
    input  logic [`SOC_DATA_WIDTH-1:0] req_wdata,
    input  logic [`SOC_DATA_WIDTH/8-1:0] req_be,
    output logic                       resp_ack,
    output logic [`SOC_DATA_WIDTH-1:0] resp_rdata,
    output logic                       resp_error,
    input  logic [`SOC_GPIO_WIDTH-1:0] gpio_in,
    output logic [`SOC_GPIO_WIDTH-1:0] gpio_out,
    output logic                       timer_irq
);

    bus_if ram_if();
    bus_if timer_if();
    bus_if gpio_if();

    data_bus data_bus_instance (
        .clk,
        .reset,
        .req_strobe,
        .req_write,
        .req_addr,
        .req_wdata,
        .req_be,
        .resp_ack,
        .resp_rdata,
        .resp_error,
        .ram   (ram_if.master),
        .timer (timer_if.master),
        .gpio  (gpio_if.master)
    );

    ram_controller ram_controller_instance (
        .clk,
        .bus (ram_if.slave)
    );

    timer_controller timer_controller_instance (
        .clk,
        .reset,
        .bus (timer_if.slave),
        .irq (timer_irq)
    );

    gpio_controller gpio_controller_instance (
        .clk,
        .reset,
        .bus      (gpio_if.slave),
        .pins_in  (gpio_in),
        .pins_out (gpio_out)
    );

endmodule

`default_nettype wire

//--- hw/gpio_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module gpio_controller (
    input  logic                       clk,
    input  logic                       reset,
    bus_if.slave                       bus,
    input  logic [`SOC_GPIO_WIDTH-1:0] pins_in,
    output logic [`SOC_GPIO_WIDTH-1:0] pins_out
);
    import bus_pkg::*;
    import periph_pkg::*;

    logic [`SOC_GPIO_WIDTH-1:0] pins_meta;
    logic [`SOC_GPIO_WIDTH-1:0] pins_sync;
    gpio_reg_t                  reg_sel;

    assign reg_sel = gpio_reg_t'(bus.addr[`SOC_REG_OFFSET_WIDTH-1:0]);

    // two-flop synchronizer
    always_ff @(posedge clk) begin
        pins_meta <= pins_in;
        pins_sync <= pins_meta;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pins_out  <= '0;
            bus.ack   <= 1'b0;
            bus.rdata <= '0;
        end else begin
            bus.ack   <= bus.strobe;
            bus.rdata <= '0;
            if (bus.strobe) begin
                case (reg_sel)
                    GPIO_OUT: begin
                        if (bus.write) begin
                            pins_out <= bus.wdata[`SOC_GPIO_WIDTH-1:0];
                        end else begin
                            bus.rdata <= word_t'(pins_out);
                        end
                    end
                    GPIO_IN: begin
                        if (!bus.write) begin
                            bus.rdata <= word_t'(pins_sync);  // read only
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/timer_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module timer_controller (
    input  logic clk,
    input  logic reset,
    bus_if.slave bus,
    output logic irq
);
    import bus_pkg::*;
    import periph_pkg::*;

    word_t      count;
    word_t      compare;
    logic       enable;
    timer_reg_t reg_sel;

    assign reg_sel = timer_reg_t'(bus.addr[`SOC_REG_OFFSET_WIDTH-1:0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= '0;
            compare   <= '0;
            enable    <= 1'b0;
            irq       <= 1'b0;
            bus.ack   <= 1'b0;
            bus.rdata <= '0;
        end else begin
            bus.ack   <= bus.strobe;
            bus.rdata <= '0;
            if (enable) begin
                count <= count + 1'b1;
            end
            if (enable && count == compare) begin
                irq <= 1'b1;  // sticky until ctrl write
            end
            if (bus.strobe && bus.write) begin
                case (reg_sel)
                    TIMER_COUNT:   count <= bus.wdata;
                    TIMER_COMPARE: compare <= bus.wdata;
                    TIMER_CTRL: begin
                        enable <= bus.wdata[0];
                        irq    <= 1'b0;
                    end
                    default: ;
                endcase
            end else if (bus.strobe) begin
                case (reg_sel)
                    TIMER_COUNT:   bus.rdata <= count;
                    TIMER_COMPARE: bus.rdata <= compare;
                    TIMER_CTRL:    bus.rdata <= word_t'(enable);
                    default:       bus.rdata <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/ram_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module ram_controller (
    input logic  clk,
    bus_if.slave bus
);
    import bus_pkg::*;

    word_t mem [`SOC_RAM_WORDS];
    logic [$clog2(`SOC_RAM_WORDS)-1:0] index;

    assign index = bus.addr[$clog2(`SOC_RAM_WORDS)+1:2];  // word address

    // byte-lane writes
    always_ff @(posedge clk) begin
        if (bus.strobe && bus.write) begin
            for (int i = 0; i < $bits(be_t); i++) begin
                if (bus.be[i]) begin
                    mem[index][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        bus.ack <= bus.strobe;
        if (bus.strobe) begin
            bus.rdata <= bus.write ? '0 : mem[index];  // full word on reads
        end
    end

    // decoder must keep out-of-range addresses away from the array
    a_in_range: assert property (@(posedge clk)
        bus.strobe |-> (bus.addr & ~`SOC_REGION_MASK) < `SOC_RAM_WORDS * 4);

endmodule

`default_nettype wire

//--- hw/data_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module data_bus (
    input  logic           clk,
    input  logic           reset,
    input  logic           req_strobe,
    input  logic           req_write,
    input  bus_pkg::addr_t req_addr,
    input  bus_pkg::word_t req_wdata,
    input  bus_pkg::be_t   req_be,
    output logic           resp_ack,
    output bus_pkg::word_t resp_rdata,
    output logic           resp_error,
    bus_if.master          ram,
    bus_if.master          timer,
    bus_if.master          gpio
);
    import bus_pkg::*;
    import periph_pkg::*;

    dev_sel_t sel;
    logic     err_pending;  // unmapped request waiting for its ack

    always_comb begin
        if ((req_addr & `SOC_REGION_MASK) == `SOC_RAM_BASE) begin
            // only the first 4 KiB of the RAM region is backed
            if ((req_addr & ~`SOC_REGION_MASK) < `SOC_RAM_WORDS * 4) begin
                sel = DEV_RAM;
            end else begin
                sel = DEV_NONE;
            end
        end else if ((req_addr & `SOC_REGION_MASK) == `SOC_TIMER_BASE) begin
            sel = DEV_TIMER;
        end else if ((req_addr & `SOC_REGION_MASK) == `SOC_GPIO_BASE) begin
            sel = DEV_GPIO;
        end else begin
            sel = DEV_NONE;
        end
    end

    assign ram.strobe   = req_strobe && sel == DEV_RAM;
    assign ram.write    = req_write;
    assign ram.addr     = req_addr;
    assign ram.wdata    = req_wdata;
    assign ram.be       = req_be;

    assign timer.strobe = req_strobe && sel == DEV_TIMER;
    assign timer.write  = req_write;
    assign timer.addr   = req_addr;
    assign timer.wdata  = req_wdata;
    assign timer.be     = req_be;

    assign gpio.strobe  = req_strobe && sel == DEV_GPIO;
    assign gpio.write   = req_write;
    assign gpio.addr    = req_addr;
    assign gpio.wdata   = req_wdata;
    assign gpio.be      = req_be;

    always_ff @(posedge clk) begin
        if (reset) begin
            err_pending <= 1'b0;
            resp_ack    <= 1'b0;
            resp_error  <= 1'b0;
        end else begin
            err_pending <= req_strobe && sel == DEV_NONE;
            resp_ack    <= ram.ack | timer.ack | gpio.ack | err_pending;
            resp_error  <= err_pending;
        end
    end

    always_ff @(posedge clk) begin
        resp_rdata <= (ram.ack ? ram.rdata : '0)
                    | (timer.ack ? timer.rdata : '0)
                    | (gpio.ack ? gpio.rdata : '0);  // error ack reads zero
    end

    a_single_slave_ack: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ram.ack, timer.ack, gpio.ack}));

    a_ack_follows_strobe: assert property (@(posedge clk) disable iff (reset)
        ({ram.ack, timer.ack, gpio.ack}
            & ~$past({ram.strobe, timer.strobe, gpio.strobe})) == 3'b000);

endmodule

`default_nettype wire

//--- hw/bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bus_if;
    import bus_pkg::*;

    logic  strobe;  // one cycle per request
    logic  write;
    addr_t addr;
    word_t wdata;
    be_t   be;
    logic  ack;     // one cycle, edge after strobe
    word_t rdata;   // valid with ack only

    modport master (
        output strobe, write, addr, wdata, be,
        input  ack, rdata
    );

    modport slave (
        input  strobe, write, addr, wdata, be,
        output ack, rdata
    );

endinterface

`default_nettype wire

//--- hw/periph_pkg.sv
`default_nettype none

`include "soc_defs.svh"

package periph_pkg;

    // target of a decoded request
    typedef enum logic [1:0] {
        DEV_RAM,
        DEV_TIMER,
        DEV_GPIO,
        DEV_NONE
    } dev_sel_t;

    typedef enum logic [`SOC_REG_OFFSET_WIDTH-1:0] {
        TIMER_COUNT   = 'h0,
        TIMER_COMPARE = 'h4,
        TIMER_CTRL    = 'h8
    } timer_reg_t;

    typedef enum logic [`SOC_REG_OFFSET_WIDTH-1:0] {
        GPIO_OUT = 'h0,
        GPIO_IN  = 'h4
    } gpio_reg_t;

endpackage

`default_nettype wire

//--- hw/bus_pkg.sv
`default_nettype none

`include "soc_defs.svh"

package bus_pkg;

    // one data word on the bus
    typedef logic [`SOC_DATA_WIDTH-1:0] word_t;

    // byte address
    typedef logic [`SOC_ADDR_WIDTH-1:0] addr_t;

    // one enable bit per byte lane
    typedef logic [`SOC_DATA_WIDTH/8-1:0] be_t;

endpackage

`default_nettype wire

//--- include/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// bus widths
`define SOC_DATA_WIDTH 32
`define SOC_ADDR_WIDTH 32

// on-chip RAM, 4 KiB
`define SOC_RAM_WORDS 1024

// address map, decoded on the top nibble
`define SOC_RAM_BASE    32'h0000_0000
`define SOC_TIMER_BASE  32'h1000_0000
`define SOC_GPIO_BASE   32'h2000_0000
`define SOC_REGION_MASK 32'hF000_0000

// peripheral register offsets live in the low address bits
`define SOC_REG_OFFSET_WIDTH 4

`define SOC_GPIO_WIDTH 16

`endif
